//--- include/seq_defines.svh
/*
 * Sizing macros for the sequence number subsystem.
 * Included by the packages and by any module that needs a raw width or depth.
 */

`ifndef SEQ_DEFINES_SVH
`define SEQ_DEFINES_SVH

// Full width of a sequence number, epoch bits included
`define SEQ_NUM_BITS 5

// Top bits of the number that form the epoch
// Two bits give four epochs of eight entries each
`define SEQ_EPOCH_BITS 2

// Most entries the tail can pass over in one cycle
`define SEQ_FREE_WIDTH 2

// Entries in the free request FIFO
`define SEQ_FREE_DEPTH 4

`endif

//--- source/seq_types_pkg.sv
/*
 * Types that describe a sequence number and its two fields.
 * Modules name these in their port lists and import the package in the body.
 */

`include "seq_defines.svh"

package seq_types_pkg;

  // Whole sequence number, epoch above offset
  typedef logic [`SEQ_NUM_BITS-1:0] seq_num_t;

  // Epoch field, the top bits of a number
  typedef logic [`SEQ_EPOCH_BITS-1:0] epoch_t;

  // Offset inside an epoch
  // Everything below the epoch field
  typedef logic [`SEQ_NUM_BITS-`SEQ_EPOCH_BITS-1:0] offset_t;

endpackage

//--- source/seq_cmp_pkg.sv
/*
 * Result encoding of the age comparator.
 * Shared by the comparator and whatever reads its answer.
 */

package seq_cmp_pkg;

  // Which of the two queried numbers was handed out first
  typedef enum logic [1:0] {
    AGE_A_OLDER = 2'd0,
    AGE_B_OLDER = 2'd1,
    AGE_SAME    = 2'd2
  } age_result_e;

endpackage

//--- source/seq_alloc_unit.sv
/*
 * Allocates sequence numbers at the head and reclaims freed ones at the tail.
 * Releases arrive out of order; the tail only passes contiguous freed entries.
 * Drives the tail epoch used for age comparisons.
 */

`timescale 1ns/1ns
`include "seq_defines.svh"

module seq_alloc_unit (
  input  logic                    clk,
  input  logic                    rst,

  // Allocation handshake
  output logic                    alloc_val,
  input  logic                    alloc_rdy,
  output seq_types_pkg::seq_num_t alloc_seq_num,

  // Release from the free FIFO, always accepted
  input  logic                    rel_val,
  input  seq_types_pkg::seq_num_t rel_seq_num,

  output seq_types_pkg::epoch_t   tail_epoch
);

  import seq_types_pkg::*;

  localparam int NUM_BITS    = $bits(seq_num_t);
  localparam int EPOCH_BITS  = $bits(epoch_t);
  localparam int OFFSET_BITS = $bits(offset_t);
  localparam int NUM_ENTRIES = 1 << `SEQ_NUM_BITS;
  localparam int FREE_WIDTH  = `SEQ_FREE_WIDTH;
  localparam int INCR_BITS   = $clog2(FREE_WIDTH + 1);

  seq_num_t               head_ptr;
  seq_num_t               tail_ptr;
  logic [NUM_ENTRIES-1:0] alloc_flags;
  logic                   alloc_fire;
  epoch_t                 head_epoch;
  epoch_t                 head_next_epoch;
  offset_t                head_offset;
  seq_num_t               live_count;
  logic [FREE_WIDTH-1:0]  reclaim_window;
  logic [FREE_WIDTH-1:0]  reclaim_run;
  logic [INCR_BITS-1:0]   tail_incr;

  // --------------------------------------------------------------------------
  // Allocation
  // --------------------------------------------------------------------------

  assign head_epoch      = head_ptr[NUM_BITS-1 -: EPOCH_BITS];
  assign head_offset     = head_ptr[OFFSET_BITS-1:0];
  assign head_next_epoch = head_epoch + epoch_t'(1);

  // Stop at the last slot of an epoch if the next epoch still holds the tail
  // Otherwise the head would wrap onto live numbers
  assign alloc_val = !((&head_offset) && (head_next_epoch == tail_epoch));

  assign alloc_fire    = alloc_val && alloc_rdy;
  assign alloc_seq_num = head_ptr;

  always_ff @(posedge clk) begin
    if (rst) begin
      head_ptr <= '0;
    end else if (alloc_fire) begin
      head_ptr <= head_ptr + seq_num_t'(1);
    end
  end

  // --------------------------------------------------------------------------
  // Per-entry flags
  // --------------------------------------------------------------------------

  // One bit per number, set while it is out with a client
  always_ff @(posedge clk) begin
    if (rst) begin
      alloc_flags <= '0;
    end else begin
      if (alloc_fire) begin
        alloc_flags[head_ptr] <= 1'b1;
      end
      // Client never releases the number being allocated, so no conflict
      if (rel_val) begin
        alloc_flags[rel_seq_num] <= 1'b0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Reclaim
  // --------------------------------------------------------------------------

  // Entries still between tail and head
  assign live_count = head_ptr - tail_ptr;

  // Freed status of the entries just above the tail, wrapping at the top
  always_comb begin
    seq_num_t idx;
    idx = tail_ptr;
    for (int j = 0; j < FREE_WIDTH; j++) begin
      idx = tail_ptr + seq_num_t'(j);
      reclaim_window[j] = !alloc_flags[idx];
    end
  end

  // Run of freed entries starting at the tail
  // Breaks at the first live entry or once it would pass the head
  always_comb begin
    logic run;
    run = 1'b1;
    for (int j = 0; j < FREE_WIDTH; j++) begin
      run = run && reclaim_window[j] && (seq_num_t'(j) < live_count);
      reclaim_run[j] = run;
    end
  end

  // Run is a thermometer code, its length is the advance
  assign tail_incr = INCR_BITS'($countones(reclaim_run));

  always_ff @(posedge clk) begin
    if (rst) begin
      tail_ptr <= '0;
    end else begin
      tail_ptr <= tail_ptr + seq_num_t'(tail_incr);
    end
  end

  // Epoch of the oldest live number, reference point for age queries
  assign tail_epoch = tail_ptr[NUM_BITS-1 -: EPOCH_BITS];

endmodule

//--- source/seq_free_fifo.sv
/*
 * Circular FIFO between the free port and the allocation unit.
 * Takes one free per cycle and hands one release per cycle downstream.
 */

`timescale 1ns/1ns
`include "seq_defines.svh"

module seq_free_fifo (
  input  logic                    clk,
  input  logic                    rst,

  // Free handshake from the client
  input  logic                    free_val,
  output logic                    free_rdy,
  input  seq_types_pkg::seq_num_t free_seq_num,

  // Release toward the allocation unit, no back-pressure
  output logic                    rel_val,
  output seq_types_pkg::seq_num_t rel_seq_num
);

  import seq_types_pkg::*;

  localparam int DEPTH    = `SEQ_FREE_DEPTH;
  localparam int PTR_BITS = $clog2(DEPTH);
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  seq_num_t            mem [DEPTH];
  logic [PTR_BITS-1:0] rd_ptr;
  logic [PTR_BITS-1:0] wr_ptr;
  logic [CNT_BITS-1:0] count;
  logic                push;
  logic                pop;

  // Full only when every slot holds a pending free
  assign free_rdy = (count != CNT_BITS'(DEPTH));
  assign push     = free_val && free_rdy;

  // Downstream always takes it, so drain whenever not empty
  assign rel_val     = (count != '0);
  assign pop         = rel_val;
  assign rel_seq_num = mem[rd_ptr];

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= free_seq_num;
    end
  end

  // Pointers wrap explicitly so depth need not be a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + PTR_BITS'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + PTR_BITS'(1);
      end
    end
  end

  // Occupancy, unchanged on simultaneous push and pop
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count <= count + CNT_BITS'(1);
        2'b01:   count <= count - CNT_BITS'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

//--- source/seq_age_cmp.sv
/*
 * Decides which of two live sequence numbers is older.
 * Purely combinational; epochs are taken relative to the current tail epoch.
 */

`timescale 1ns/1ns

module seq_age_cmp (
  input  seq_types_pkg::epoch_t     tail_epoch,
  input  seq_types_pkg::seq_num_t   query_a,
  input  seq_types_pkg::seq_num_t   query_b,
  output seq_cmp_pkg::age_result_e  age_result
);

  import seq_types_pkg::*;
  import seq_cmp_pkg::*;

  localparam int NUM_BITS    = $bits(seq_num_t);
  localparam int EPOCH_BITS  = $bits(epoch_t);
  localparam int OFFSET_BITS = $bits(offset_t);

  epoch_t  rel_epoch_a;
  epoch_t  rel_epoch_b;
  offset_t offset_a;
  offset_t offset_b;

  // Distance from the tail epoch, wrapping modulo the epoch count
  // The tail epoch maps to zero, so smaller means older
  assign rel_epoch_a = query_a[NUM_BITS-1 -: EPOCH_BITS] - tail_epoch;
  assign rel_epoch_b = query_b[NUM_BITS-1 -: EPOCH_BITS] - tail_epoch;

  assign offset_a = query_a[OFFSET_BITS-1:0];
  assign offset_b = query_b[OFFSET_BITS-1:0];

  always_comb begin
    if (rel_epoch_a < rel_epoch_b) begin
      age_result = AGE_A_OLDER;
    end else if (rel_epoch_b < rel_epoch_a) begin
      age_result = AGE_B_OLDER;
    end else if (offset_a < offset_b) begin
      // Same epoch, lower offset was handed out first
      age_result = AGE_A_OLDER;
    end else if (offset_b < offset_a) begin
      age_result = AGE_B_OLDER;
    end else begin
      age_result = AGE_SAME;
    end
  end

endmodule

//--- source/seq_num_top.sv
/*
 * Top of the sequence number subsystem.
 * Frees pass through the FIFO into the allocation unit; the comparator
 * answers age queries against the allocation unit's tail epoch.
 */

`timescale 1ns/1ns

module seq_num_top (
  input  logic                     clk,
  input  logic                     rst,

  // Allocation port
  output logic                     alloc_val,
  input  logic                     alloc_rdy,
  output seq_types_pkg::seq_num_t  alloc_seq_num,

  // Free port
  input  logic                     free_val,
  output logic                     free_rdy,
  input  seq_types_pkg::seq_num_t  free_seq_num,

  // Age port
  input  seq_types_pkg::seq_num_t  query_a,
  input  seq_types_pkg::seq_num_t  query_b,
  output seq_cmp_pkg::age_result_e age_result,

  output seq_types_pkg::epoch_t    tail_epoch
);

  import seq_types_pkg::*;

  // FIFO to allocation unit
  logic     rel_val;
  seq_num_t rel_seq_num;

  seq_free_fifo free_fifo_i (
    .clk          (clk),
    .rst          (rst),
    .free_val     (free_val),
    .free_rdy     (free_rdy),
    .free_seq_num (free_seq_num),
    .rel_val      (rel_val),
    .rel_seq_num  (rel_seq_num)
  );

  seq_alloc_unit alloc_unit_i (
    .clk           (clk),
    .rst           (rst),
    .alloc_val     (alloc_val),
    .alloc_rdy     (alloc_rdy),
    .alloc_seq_num (alloc_seq_num),
    .rel_val       (rel_val),
    .rel_seq_num   (rel_seq_num),
    .tail_epoch    (tail_epoch)
  );

  // Same tail epoch feeds the comparator and the top output
  seq_age_cmp age_cmp_i (
    .tail_epoch (tail_epoch),
    .query_a    (query_a),
    .query_b    (query_b),
    .age_result (age_result)
  );

endmodule

//--- test/tb_clock_gen.sv
/*
 * Free-running clock for the testbench, 50% duty cycle.
 */

`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

//--- test/seq_num_chk.sv
/*
 * Concurrent assertions on the head and tail pointers of the allocation unit.
 * Bound into every seq_alloc_unit instance by the bind at the end of the file.
 */

`timescale 1ns/1ns
`include "seq_defines.svh"

module seq_num_chk (
  input logic                    clk,
  input logic                    rst,
  input logic                    alloc_val,
  input seq_types_pkg::seq_num_t head_ptr,
  input seq_types_pkg::seq_num_t tail_ptr
);

  import seq_types_pkg::*;

  localparam int NUM_ENTRIES = 1 << `SEQ_NUM_BITS;

  // Nothing is live right after reset, so allocation must be open
  alloc_open_after_reset: assert property (
    @(posedge clk) $fell(rst) |-> alloc_val
  ) else $error("alloc_val low in the first cycle after reset");

  // Tail passes at most the reclaim window per edge, and never the head
  tail_step_bounded: assert property (
    @(posedge clk) disable iff (rst)
    !$past(rst) |->
      (seq_num_t'(tail_ptr - $past(tail_ptr)) <= seq_num_t'(`SEQ_FREE_WIDTH)) &&
      (seq_num_t'(tail_ptr - $past(tail_ptr)) <=
       seq_num_t'($past(head_ptr) - $past(tail_ptr)))
  ) else $error("tail pointer moved further than the reclaim width or past the head");

  // With every other slot live the head must hold
  // Otherwise it would step onto the tail's slot
  live_span_bounded: assert property (
    @(posedge clk) disable iff (rst)
    !$past(rst) &&
    (seq_num_t'($past(head_ptr) - $past(tail_ptr)) == seq_num_t'(NUM_ENTRIES - 1))
      |-> (head_ptr == $past(head_ptr))
  ) else $error("head is further ahead of the tail than the number space allows");

endmodule

bind seq_alloc_unit seq_num_chk alloc_chk_i (
  .clk       (clk),
  .rst       (rst),
  .alloc_val (alloc_val),
  .head_ptr  (head_ptr),
  .tail_ptr  (tail_ptr)
);

//--- test/seq_num_tb.sv
/*
 * Testbench for the sequence number subsystem: random allocations, frees
 * and age queries checked against a queue model, then a free burst and a
 * full drain that waits for the tail epoch to reach the head.
 */

`timescale 1ns/1ns
`include "seq_defines.svh"

module seq_num_tb;

  import seq_types_pkg::*;
  import seq_cmp_pkg::*;

  localparam int NUM_BITS      = `SEQ_NUM_BITS;
  localparam int EPOCH_BITS    = `SEQ_EPOCH_BITS;
  localparam int OFFSET_BITS   = NUM_BITS - EPOCH_BITS;
  localparam int FIFO_DEPTH    = `SEQ_FREE_DEPTH;
  localparam int RANDOM_CYCLES = 1500;
  localparam int WAIT_LIMIT    = 200;
  localparam int STALL_LIMIT   = 40;

  logic        clk;
  logic        rst;
  logic        alloc_val;
  logic        alloc_rdy;
  seq_num_t    alloc_seq_num;
  logic        free_val;
  logic        free_rdy;
  seq_num_t    free_seq_num;
  seq_num_t    query_a;
  seq_num_t    query_b;
  age_result_e age_result;
  epoch_t      tail_epoch;

  // Model: live numbers in allocation order, oldest first
  seq_num_t    live_q[$];
  seq_num_t    model_head;
  int          fifo_count;
  int          free_wait;
  int          stall_cycles;
  int          frees_taken;
  logic        query_pending;
  age_result_e expect_age;

  // Stimulus knobs, percent per cycle
  int unsigned alloc_pct;
  int unsigned free_pct;
  logic        query_on;

  int unsigned lcg_state;
  int          error_count;
  int          check_count;
  logic        run_ok;

  tb_clock_gen #(.PERIOD_NS(100)) clk_gen_i (.clk(clk));

  seq_num_top dut_i (
    .clk           (clk),
    .rst           (rst),
    .alloc_val     (alloc_val),
    .alloc_rdy     (alloc_rdy),
    .alloc_seq_num (alloc_seq_num),
    .free_val      (free_val),
    .free_rdy      (free_rdy),
    .free_seq_num  (free_seq_num),
    .query_a       (query_a),
    .query_b       (query_b),
    .age_result    (age_result),
    .tail_epoch    (tail_epoch)
  );

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  // 32-bit LCG, upper bits are the better ones
  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state >> 8;
  endfunction

  function automatic int unsigned rand_below(input int unsigned limit);
    return lcg_next() % limit;
  endfunction

  function automatic int find_live(input seq_num_t num);
    int pos;
    pos = -1;
    for (int i = 0; i < live_q.size(); i++) begin
      if (live_q[i] == num) begin
        pos = i;
      end
    end
    return pos;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  // --------------------------------------------------------------------------
  // One clock: check pre-edge outputs, update model, drive next inputs
  // --------------------------------------------------------------------------

  task automatic cycle_step();
    logic    alloc_fire;
    logic    free_fire;
    int      idx;
    int      ia;
    int      ib;
    epoch_t  head_epoch;
    offset_t head_offset;
    @(posedge clk);
    alloc_fire  = alloc_val && alloc_rdy;
    free_fire   = free_val && free_rdy;
    head_epoch  = model_head[NUM_BITS-1 -: EPOCH_BITS];
    head_offset = model_head[OFFSET_BITS-1:0];

    // Free port only blocks on a full FIFO
    check_value(32'(free_rdy), 32'(fifo_count != FIFO_DEPTH), "free_rdy");

    // Stall only at the last slot before the tail's epoch
    if (!alloc_val) begin
      check_value(32'(&head_offset), 32'd1, "head offset while alloc_val low");
      check_value(32'(epoch_t'(head_epoch + epoch_t'(1))), 32'(tail_epoch),
                  "next head epoch while alloc_val low");
      if (live_q.size() == 0) begin
        stall_cycles++;
        if (stall_cycles == STALL_LIMIT) begin
          report_error("alloc_val stayed low after every number was freed");
        end
      end
    end else begin
      stall_cycles = 0;
    end

    if (query_pending) begin
      check_value(32'(age_result), 32'(expect_age), "age_result");
    end

    if (alloc_fire) begin
      check_value(32'(alloc_seq_num), 32'(model_head), "alloc_seq_num");
      live_q.push_back(model_head);
      model_head = model_head + seq_num_t'(1);
    end

    // FIFO drains one entry per cycle whenever it holds one
    if (fifo_count != 0) begin
      fifo_count--;
    end
    if (free_fire) begin
      fifo_count++;
      idx = find_live(free_seq_num);
      if (idx < 0) begin
        report_error("accepted free names a number that is not live");
      end else begin
        live_q.delete(idx);
      end
      frees_taken++;
    end else if (free_val) begin
      free_wait++;
      if (free_wait == WAIT_LIMIT) begin
        report_error("offered free was not accepted in time");
      end
    end

    alloc_rdy <= (rand_below(100) < alloc_pct);

    // An offered free holds until taken or given up
    if (!free_val || free_fire || free_wait >= WAIT_LIMIT) begin
      free_wait = 0;
      if (live_q.size() != 0 && rand_below(100) < free_pct) begin
        idx = int'(rand_below(live_q.size()));
        free_val     <= 1'b1;
        free_seq_num <= live_q[idx];
      end else begin
        free_val <= 1'b0;
      end
    end

    query_pending = 1'b0;
    if (query_on && live_q.size() != 0) begin
      ia = int'(rand_below(live_q.size()));
      ib = int'(rand_below(live_q.size()));
      query_a <= live_q[ia];
      query_b <= live_q[ib];
      // Lower queue position was handed out first
      if (ia < ib) begin
        expect_age = AGE_A_OLDER;
      end else if (ib < ia) begin
        expect_age = AGE_B_OLDER;
      end else begin
        expect_age = AGE_SAME;
      end
      query_pending = 1'b1;
    end
  endtask

  // --------------------------------------------------------------------------
  // Phases, each wait bounded
  // --------------------------------------------------------------------------

  task automatic fill_live(input int target, output logic ok);
    int waited;
    alloc_pct = 100;
    free_pct  = 0;
    waited    = 0;
    while (live_q.size() < target && waited < WAIT_LIMIT) begin
      cycle_step();
      waited++;
    end
    ok = (live_q.size() >= target);
    if (!ok) begin
      report_error("could not allocate enough numbers for the free burst");
    end
  endtask

  // Back-to-back frees, one new offer every cycle
  task automatic free_burst(input int count, output logic ok);
    int waited;
    int start;
    alloc_pct = 0;
    free_pct  = 100;
    waited    = 0;
    start     = frees_taken;
    while (frees_taken - start < count && waited < WAIT_LIMIT) begin
      cycle_step();
      waited++;
    end
    ok = (frees_taken - start >= count);
    if (!ok) begin
      report_error("free burst was not accepted in time");
    end
  endtask

  task automatic drain_all(output logic ok);
    int     waited;
    epoch_t head_epoch;
    alloc_pct = 0;
    free_pct  = 100;
    waited    = 0;
    while ((live_q.size() != 0 || free_val) && waited < WAIT_LIMIT) begin
      cycle_step();
      waited++;
    end
    ok = (live_q.size() == 0) && !free_val;
    if (!ok) begin
      report_error("live numbers were not all freed in time");
    end

    // Releases still in flight through the FIFO
    waited = 0;
    while (ok && fifo_count != 0 && waited < WAIT_LIMIT) begin
      cycle_step();
      waited++;
    end
    if (ok && fifo_count != 0) begin
      ok = 1'b0;
      report_error("free FIFO did not drain in time");
    end

    // Tail walks over the freed entries up to the head
    waited     = 0;
    head_epoch = model_head[NUM_BITS-1 -: EPOCH_BITS];
    while (ok && tail_epoch != head_epoch && waited < WAIT_LIMIT) begin
      cycle_step();
      waited++;
    end
    if (ok && tail_epoch != head_epoch) begin
      ok = 1'b0;
      report_error("tail epoch did not reach the head epoch after the drain");
    end
  endtask

  initial begin
    rst           = 1'b1;
    alloc_rdy     = 1'b0;
    free_val      = 1'b0;
    free_seq_num  = '0;
    query_a       = '0;
    query_b       = '0;
    lcg_state     = 32'h91dc;
    model_head    = '0;
    fifo_count    = 0;
    free_wait     = 0;
    stall_cycles  = 0;
    frees_taken   = 0;
    query_pending = 1'b0;
    expect_age    = AGE_SAME;
    error_count   = 0;
    check_count   = 0;
    run_ok        = 1'b1;

    repeat (2) @(posedge clk);
    rst <= 1'b0;
    check_value(32'(alloc_val), 32'd1, "alloc_val after reset");
    check_value(32'(tail_epoch), 32'd0, "tail_epoch after reset");

    // Mixed traffic, wraps the epochs several times
    alloc_pct = 70;
    free_pct  = 55;
    query_on  = 1'b1;
    repeat (RANDOM_CYCLES) cycle_step();

    // Start the burst from an empty window
    drain_all(run_ok);
    if (run_ok) begin
      fill_live(FIFO_DEPTH + 2, run_ok);
    end
    if (run_ok) begin
      free_burst(FIFO_DEPTH + 1, run_ok);
    end
    if (run_ok) begin
      drain_all(run_ok);
    end
    if (run_ok) begin
      check_value(32'(alloc_val), 32'd1, "alloc_val after drain");
    end

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
source/seq_types_pkg.sv
source/seq_cmp_pkg.sv
source/seq_alloc_unit.sv
source/seq_free_fifo.sv
source/seq_age_cmp.sv
source/seq_num_top.sv
test/tb_clock_gen.sv
test/seq_num_chk.sv
test/seq_num_tb.sv

//--- Makefile
TOP = seq_num_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f tb.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
